//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_weight_buffer
RTL_TOP   ?= weight_buffer_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Done: no errors

RTL_SRCS = weight_cfg_pkg.sv axil_pkg.sv sdp_ram.sv axil_weight_loader.sv \
           weight_row_streamer.sv weight_buffer_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only -Wall $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- axil_pkg.sv
`default_nettype none

package axil_pkg;

  localparam int ADDR_WIDTH = 12;
  localparam int DATA_WIDTH = 32;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // weights live below WEIGHT_SPAN, control registers above.
  localparam logic [ADDR_WIDTH-1:0] REG_CTRL    = 12'h100;
  localparam logic [ADDR_WIDTH-1:0] REG_STATUS  = 12'h104;
  localparam logic [ADDR_WIDTH-1:0] WEIGHT_SPAN = 12'h100;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
  } axil_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [1:0]            resp;
  } axil_r_t;

endpackage

`default_nettype wire

//--- axil_weight_loader.sv
`default_nettype none

module axil_weight_loader (
  input  logic                     clkb,
  input  logic                     reset,
  input  axil_pkg::axil_aw_t       aw,
  input  logic                     awvalid,
  output logic                     awready,
  input  axil_pkg::axil_w_t        w,
  input  logic                     wvalid,
  output logic                     wready,
  output axil_pkg::axil_b_t        b,
  output logic                     bvalid,
  input  logic                     bready,
  input  axil_pkg::axil_ar_t       ar,
  input  logic                     arvalid,
  output logic                     arready,
  output axil_pkg::axil_r_t        r,
  output logic                     rvalid,
  input  logic                     rready,
  output weight_cfg_pkg::bank_wr_t bank_wr,
  output logic                     wr_en,
  output logic                     start,
  output weight_cfg_pkg::row_cnt_t row_count,
  input  logic                     busy,
  input  weight_cfg_pkg::row_cnt_t delivered
);
  import axil_pkg::*;
  import weight_cfg_pkg::*;

  logic                  wr_accept;
  logic                  rd_accept;
  logic                  is_weight;
  logic                  is_ctrl;
  logic                  ctrl_busy;
  row_cnt_t              ctrl_count;
  logic [DATA_WIDTH-1:0] status;

  assign wr_accept  = awready && awvalid && wvalid;
  assign is_weight  = aw.addr < WEIGHT_SPAN;
  assign is_ctrl    = aw.addr == REG_CTRL;
  assign ctrl_count = w.data[$bits(row_cnt_t)-1:0];

  // a start still in flight counts as busy.
  assign ctrl_busy = busy || start;

  // broadcast to all banks on the accepting edge.
  assign wr_en             = wr_accept && is_weight;
  assign bank_wr.bank_sel  = aw.addr[W_ADDR_WIDTH+2 +: BANK_SEL_WIDTH];
  assign bank_wr.word_addr = aw.addr[2 +: W_ADDR_WIDTH];
  assign bank_wr.data      = w.data;

  always_ff @(posedge clkb) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      start   <= 1'b0;
    end else begin
      // one-cycle ready pulse, both channels together.
      awready <= awvalid && wvalid && !bvalid && !awready;
      wready  <= awvalid && wvalid && !bvalid && !awready;
      start   <= wr_accept && is_ctrl && !ctrl_busy && ctrl_count != '0;
      if (wr_accept) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clkb) begin
    if (wr_accept) begin
      if (is_weight || (is_ctrl && !ctrl_busy)) begin
        b.resp <= RESP_OKAY;
      end else begin
        b.resp <= RESP_SLVERR;
      end
    end
    if (wr_accept && is_ctrl) begin
      row_count <= ctrl_count;
    end
  end

  assign arready   = !rvalid;
  assign rd_accept = arvalid && arready;

  always_comb begin
    status                        = '0;
    status[0]                     = busy;
    status[8 +: $bits(row_cnt_t)] = delivered;
  end

  always_ff @(posedge clkb) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clkb) begin
    if (rd_accept) begin
      if (ar.addr == REG_STATUS) begin
        r.data <= status;
        r.resp <= RESP_OKAY;
      end else begin
        r.data <= '0;
        r.resp <= RESP_SLVERR;
      end
    end
  end

endmodule

`default_nettype wire

//--- compile.f
weight_cfg_pkg.sv
axil_pkg.sv
sdp_ram.sv
axil_weight_loader.sv
weight_row_streamer.sv
weight_buffer_top.sv
tb_weight_buffer.sv

//--- sdp_ram.sv
`default_nettype none

module sdp_ram #(
  parameter int bank_index = 0
) (
  input  logic                                    clkb,
  input  logic                                    wr_en,
  input  weight_cfg_pkg::bank_wr_t                bank_wr,
  input  logic                                    rd_en,
  input  logic [weight_cfg_pkg::R_ADDR_WIDTH-1:0] rd_addr,
  output logic [weight_cfg_pkg::R_DATA_WIDTH-1:0] rd_data
);
  import weight_cfg_pkg::*;

  logic [W_DEPTH-1:0][W_DATA_WIDTH-1:0] mem;
  logic [R_DEPTH-1:0][R_DATA_WIDTH-1:0] mem_bytes;
  logic [LATENCY-1:0][R_DATA_WIDTH-1:0] pipe;
  logic                                 bank_hit;

  assign bank_hit = bank_wr.bank_sel == BANK_SEL_WIDTH'(bank_index);

  // same bits seen as bytes, lowest byte of word 0 first.
  assign mem_bytes = mem;

  always_ff @(posedge clkb) begin
    if (wr_en && bank_hit) begin
      mem[bank_wr.word_addr] <= bank_wr.data;
    end
  end

  // stage 0 samples the array, the top stage is the output.
  always_ff @(posedge clkb) begin
    if (rd_en) begin
      pipe <= (LATENCY * R_DATA_WIDTH)'({pipe, mem_bytes[rd_addr]});
    end
  end

  assign rd_data = pipe[LATENCY-1];

endmodule

`default_nettype wire

//--- tb_weight_buffer.sv
`default_nettype none

module tb_weight_buffer;
  import weight_cfg_pkg::*;
  import axil_pkg::*;

  localparam logic [1:0] OP_WR    = 2'd0;
  localparam logic [1:0] OP_RD    = 2'd1;
  localparam logic [1:0] OP_DRAIN = 2'd2;
  localparam int OP_CYCLES    = 16;
  localparam int STALL_CYCLES = 8;

  typedef struct packed {
    logic [1:0]            kind;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    logic [1:0]            resp;
    logic [DATA_WIDTH-1:0] rdata;
  } op_t;

  logic        clkb;
  logic        reset;
  axil_aw_t    aw;
  logic        awvalid;
  logic        awready;
  axil_w_t     w;
  logic        wvalid;
  logic        wready;
  axil_b_t     b;
  logic        bvalid;
  logic        bready;
  axil_ar_t    ar;
  logic        arvalid;
  logic        arready;
  axil_r_t     r;
  logic        rvalid;
  logic        rready;
  weight_row_t row;
  logic        row_valid;
  logic        row_ready;

  op_t                     ops[$];
  logic [W_DATA_WIDTH-1:0] model[NUM_BANKS][W_DEPTH];
  logic [31:0]             lcg_state;
  int                      errors = 0;
  int                      checks = 0;
  int                      cycles = 0;
  int                      limit = 0;

  weight_buffer_top DUT (.*);

  always #20 clkb = ~clkb;

  always @(posedge clkb) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // weight r of bank b is byte r mod 4 of word r/4.
  function automatic logic [31:0] expected_row(input int idx);
    weight_row_t exp;
    for (int bank = 0; bank < NUM_BANKS; bank++) begin
      exp[bank] = R_DATA_WIDTH'(model[bank][W_ADDR_WIDTH'(idx / 4)] >> (R_DATA_WIDTH * (idx % 4)));
    end
    return exp;
  endfunction

  function automatic logic [31:0] status_word(input logic busy_bit, input row_cnt_t count);
    return DATA_WIDTH'({count, 7'b0, busy_bit});
  endfunction

  task automatic add_op(input logic [1:0] kind, input logic [ADDR_WIDTH-1:0] addr,
                        input logic [31:0] data, input logic [1:0] resp,
                        input logic [31:0] rdata);
    ops.push_back('{kind, addr, data, resp, rdata});
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic write_axil(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                            input logic [1:0] resp);
    row_ready = 1'b0;
    aw.addr   = addr;
    w.data    = data;
    awvalid   = 1'b1;
    wvalid    = 1'b1;
    @(negedge clkb);
    while (!awready) @(negedge clkb);
    compare_value("wready", 32'(wready), 32'd1);
    compare_value("bvalid", 32'(bvalid), 32'd0);
    // accepting edge lies between these two falling edges.
    @(negedge clkb);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    compare_value("awready", 32'(awready), 32'd0);
    compare_value("bvalid", 32'(bvalid), 32'd1);
    compare_value("b.resp", 32'(b.resp), 32'(resp));
  endtask

  task automatic read_axil(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] rdata,
                           input logic [1:0] resp);
    row_ready = 1'b0;
    while (!arready) @(negedge clkb);
    ar.addr = addr;
    arvalid = 1'b1;
    @(negedge clkb);
    arvalid = 1'b0;
    compare_value("rvalid", 32'(rvalid), 32'd1);
    compare_value("arready", 32'(arready), 32'd0);
    compare_value("r.data", r.data, rdata);
    compare_value("r.resp", 32'(r.resp), 32'(resp));
  endtask

  task automatic drain_rows(input int count);
    int          idx;
    logic [31:0] rnd;
    idx = 0;
    while (idx < count) begin
      rnd       = lcg_next();
      row_ready = rnd[20] | rnd[27];
      if (row_valid && row_ready) begin
        compare_value("row", row, expected_row(idx));
        idx++;
      end
      @(negedge clkb);
    end
    // no row may follow the last one.
    row_ready = 1'b1;
    repeat (LATENCY + 4) begin
      compare_value("row_valid", 32'(row_valid), 32'd0);
      @(negedge clkb);
    end
    row_ready = 1'b0;
  endtask

  initial begin
    logic [31:0] word_data;
    clkb      = 1'b0;
    reset     = 1'b1;
    aw        = '0;
    awvalid   = 1'b0;
    w         = '0;
    wvalid    = 1'b0;
    bready    = 1'b1;
    ar        = '0;
    arvalid   = 1'b0;
    rready    = 1'b1;
    row_ready = 1'b0;
    lcg_state = 32'h20134981;

    // bank in address bits 7:6, word in bits 5:2.
    for (int bank = 0; bank < NUM_BANKS; bank++) begin
      for (int word = 0; word < W_DEPTH; word++) begin
        word_data         = lcg_next();
        model[bank][word] = word_data;
        add_op(OP_WR, ADDR_WIDTH'((bank << 6) | (word << 2)), word_data, RESP_OKAY, '0);
      end
    end
    add_op(OP_WR, REG_CTRL, 32'd64, RESP_OKAY, '0);
    add_op(OP_WR, REG_CTRL, 32'd3, RESP_SLVERR, '0);
    add_op(OP_RD, REG_STATUS, '0, RESP_OKAY, status_word(1'b1, 7'd0));
    add_op(OP_RD, 12'h200, '0, RESP_SLVERR, '0);
    add_op(OP_WR, 12'h300, 32'h0000_dead, RESP_SLVERR, '0);
    add_op(OP_DRAIN, '0, 32'd64, RESP_OKAY, '0);
    add_op(OP_WR, REG_CTRL, 32'd5, RESP_OKAY, '0);
    add_op(OP_DRAIN, '0, 32'd5, RESP_OKAY, '0);
    add_op(OP_RD, REG_STATUS, '0, RESP_OKAY, status_word(1'b0, 7'd5));
    add_op(OP_WR, REG_CTRL, 32'd0, RESP_OKAY, '0);
    add_op(OP_DRAIN, '0, 32'd0, RESP_OKAY, '0);
    add_op(OP_RD, REG_STATUS, '0, RESP_OKAY, status_word(1'b0, 7'd5));
    limit = ops.size() * OP_CYCLES + 2 * R_DEPTH * STALL_CYCLES;

    repeat (3) @(posedge clkb);
    @(negedge clkb);
    reset = 1'b0;

    foreach (ops[i]) begin
      case (ops[i].kind)
        OP_WR:    write_axil(ops[i].addr, ops[i].data, ops[i].resp);
        OP_RD:    read_axil(ops[i].addr, ops[i].rdata, ops[i].resp);
        default:  drain_rows(int'(ops[i].data));
      endcase
    end

    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- weight_buffer_top.sv
`default_nettype none

module weight_buffer_top (
  input  logic                        clkb,
  input  logic                        reset,
  input  axil_pkg::axil_aw_t          aw,
  input  logic                        awvalid,
  output logic                        awready,
  input  axil_pkg::axil_w_t           w,
  input  logic                        wvalid,
  output logic                        wready,
  output axil_pkg::axil_b_t           b,
  output logic                        bvalid,
  input  logic                        bready,
  input  axil_pkg::axil_ar_t          ar,
  input  logic                        arvalid,
  output logic                        arready,
  output axil_pkg::axil_r_t           r,
  output logic                        rvalid,
  input  logic                        rready,
  output weight_cfg_pkg::weight_row_t row,
  output logic                        row_valid,
  input  logic                        row_ready
);
  import weight_cfg_pkg::*;

  bank_wr_t                bank_wr;
  logic                    wr_en;
  logic                    start;
  row_cnt_t                row_count;
  logic                    busy;
  row_cnt_t                delivered;
  logic                    rd_en;
  logic [R_ADDR_WIDTH-1:0] rd_addr;
  weight_row_t             bank_data;

  axil_weight_loader u_loader (
    .clkb      (clkb),
    .reset     (reset),
    .aw        (aw),
    .awvalid   (awvalid),
    .awready   (awready),
    .w         (w),
    .wvalid    (wvalid),
    .wready    (wready),
    .b         (b),
    .bvalid    (bvalid),
    .bready    (bready),
    .ar        (ar),
    .arvalid   (arvalid),
    .arready   (arready),
    .r         (r),
    .rvalid    (rvalid),
    .rready    (rready),
    .bank_wr   (bank_wr),
    .wr_en     (wr_en),
    .start     (start),
    .row_count (row_count),
    .busy      (busy),
    .delivered (delivered)
  );

  // bank g supplies byte g of every row.
  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    sdp_ram #(
      .bank_index (g)
    ) u_bank (
      .clkb    (clkb),
      .wr_en   (wr_en),
      .bank_wr (bank_wr),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (bank_data[g])
    );
  end

  weight_row_streamer u_streamer (
    .clkb      (clkb),
    .reset     (reset),
    .start     (start),
    .row_count (row_count),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .bank_data (bank_data),
    .row       (row),
    .row_valid (row_valid),
    .row_ready (row_ready),
    .busy      (busy),
    .delivered (delivered)
  );

endmodule

`default_nettype wire

//--- weight_cfg_pkg.sv
`default_nettype none

package weight_cfg_pkg;

  localparam int NUM_BANKS      = 4;
  localparam int R_DEPTH        = 64;
  localparam int R_DATA_WIDTH   = 8;
  localparam int W_DATA_WIDTH   = 32;
  localparam int W_DEPTH        = R_DEPTH * R_DATA_WIDTH / W_DATA_WIDTH;
  localparam int R_ADDR_WIDTH   = $clog2(R_DEPTH);
  localparam int W_ADDR_WIDTH   = $clog2(W_DEPTH);
  localparam int LATENCY        = 2;
  localparam int BANK_SEL_WIDTH = $clog2(NUM_BANKS);

  // one extra bit so a full bank of rows fits.
  typedef logic [R_ADDR_WIDTH:0] row_cnt_t;

  typedef logic [NUM_BANKS-1:0][R_DATA_WIDTH-1:0] weight_row_t;

  typedef struct packed {
    logic [BANK_SEL_WIDTH-1:0] bank_sel;
    logic [W_ADDR_WIDTH-1:0]   word_addr;
    logic [W_DATA_WIDTH-1:0]   data;
  } bank_wr_t;

endpackage

`default_nettype wire

//--- weight_row_streamer.sv
`default_nettype none

module weight_row_streamer (
  input  logic                                    clkb,
  input  logic                                    reset,
  input  logic                                    start,
  input  weight_cfg_pkg::row_cnt_t                row_count,
  output logic                                    rd_en,
  output logic [weight_cfg_pkg::R_ADDR_WIDTH-1:0] rd_addr,
  input  weight_cfg_pkg::weight_row_t             bank_data,
  output weight_cfg_pkg::weight_row_t             row,
  output logic                                    row_valid,
  input  logic                                    row_ready,
  output logic                                    busy,
  output weight_cfg_pkg::row_cnt_t                delivered
);
  import weight_cfg_pkg::*;

  row_cnt_t           count_q;
  row_cnt_t           issued;
  logic               issue;
  logic               accept;
  logic               last_row;
  logic [LATENCY-1:0] stage_vld;

  // valid bits track the bank read pipelines stage for stage.
  assign row_valid = stage_vld[LATENCY-1];
  assign row       = bank_data;
  assign accept    = row_valid && row_ready;

  // a waiting row freezes banks and valid bits alike.
  assign rd_en = busy && !(row_valid && !row_ready);

  assign issue    = issued != count_q;
  assign rd_addr  = issued[R_ADDR_WIDTH-1:0];
  assign last_row = delivered + row_cnt_t'(1) == count_q;

  always_ff @(posedge clkb) begin
    if (reset) begin
      busy      <= 1'b0;
      count_q   <= '0;
      issued    <= '0;
      delivered <= '0;
      stage_vld <= '0;
    end else if (start && !busy) begin
      busy      <= 1'b1;
      count_q   <= row_count;
      issued    <= '0;
      delivered <= '0;
    end else begin
      if (rd_en) begin
        stage_vld <= LATENCY'({stage_vld, issue});
        if (issue) begin
          issued <= issued + row_cnt_t'(1);
        end
      end
      if (accept) begin
        delivered <= delivered + row_cnt_t'(1);
        // nothing behind the last row, so the pipeline is empty.
        if (last_row) begin
          busy <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire
